// ==== sl_core_pkg.sv ====
// -------------------------------------------------------------------------
// core-side record types seen by the support logic
// retire_t follows RVFI naming; one record per cycle, valid marks a retirement
// -------------------------------------------------------------------------
package sl_core_pkg;

  // -------------------------------------------------------------------------
  // program counter source, as driven by the controller FSM
  // -------------------------------------------------------------------------
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_TRAP_EXC = 3'd3,
    PC_TRAP_DBE = 3'd4,
    PC_DRET     = 3'd5,
    PC_OTHER    = 3'd6
  } pc_mux_e;

  // retirement record, 24 bits
  typedef struct packed {
    // retire strobe
    logic        valid;
    logic        dbg_mode;
    // instruction was a dret
    logic        is_dret;
    logic        trap;
    logic        exception;
    logic [4:0]  exc_cause;
    // privilege of the retiring instruction
    logic        is_mmode;
    logic        is_umode;
    // retirement is the first one of an interrupt handler
    logic        intr;
    logic [10:0] intr_cause;
  } retire_t;

  // controller outputs of interest
  typedef struct packed {
    logic    pc_set;
    pc_mux_e pc_mux;
  } ctrl_t;

  // trigger CSR write port, writes the selected tdata1/tdata2 pair at once
  typedef struct packed {
    logic        wr;
    logic [2:0]  tsel;
    logic [31:0] tdata1;
    logic [31:0] tdata2;
  } trig_wr_t;

  // -------------------------------------------------------------------------
  // trigger field positions in tdata1
  // -------------------------------------------------------------------------
  localparam int TRIG_TYPE_LSB      = 28;
  localparam int TRIG_TYPE_MSB      = 31;
  // etrigger type encoding
  localparam int TRIG_TYPE_ETRIGGER = 5;
  // mode enables of an etrigger
  localparam int TRIG_ET_M_BIT      = 9;
  localparam int TRIG_ET_U_BIT      = 6;

  localparam logic [31:0] TDATA1_RESET = 32'hF800_0000;

  // size of the trigger storage, implemented count may be lower
  localparam int MAX_TRIGGERS = 5;

endpackage

// ==== sl_bus_pkg.sv ====
// -------------------------------------------------------------------------
// OBI sample and phase status types; count field width is fixed here
// modules that fill obi_phase_t must use a CNT_W equal to sl_bus_pkg::CNT_W
// -------------------------------------------------------------------------
package sl_bus_pkg;

  // width of the accepted-address count in the status struct
  localparam int CNT_W = 8;

  // -------------------------------------------------------------------------
  // one cycle of OBI handshake signals
  // -------------------------------------------------------------------------
  typedef struct packed {
    // address phase request
    logic req;
    // address phase grant
    logic gnt;
    // response phase valid
    logic rvalid;
  } obi_bus_t;

  // -------------------------------------------------------------------------
  // derived phase status of one bus
  // -------------------------------------------------------------------------
  typedef struct packed {
    // request is held over from an ungranted cycle
    logic             addr_ph_cont;
    // at least one response is still owed
    logic             resp_ph_cont;
    // accepted address phases since reset, saturating
    logic [CNT_W-1:0] addr_cnt;
  } obi_phase_t;

endpackage

// ==== obi_phase_monitor.sv ====
// -------------------------------------------------------------------------
// phase tracker for one OBI bus; assumes in-order, legal handshakes
// CNT_W must match sl_bus_pkg::CNT_W, the outstanding count never underflows
// -------------------------------------------------------------------------
module obi_phase_monitor #(
  parameter int CNT_W = 8
) (
  input  logic                   in_support_if,
  input  logic                   rst_n_i,
  input  sl_bus_pkg::obi_bus_t   bus_i,
  output sl_bus_pkg::obi_phase_t phase_o
);

  // address phase accepted this cycle
  logic             addr_acc;
  // req was high without gnt last cycle
  logic             wait_q;
  // requests accepted but not yet answered
  logic [CNT_W-1:0] outst_q;
  logic [CNT_W-1:0] addr_cnt_q;

  assign addr_acc = bus_i.req && bus_i.gnt;

  // -------------------------------------------------------------------------
  // status outputs
  // -------------------------------------------------------------------------
  // continuation only while the request is still held
  assign phase_o.addr_ph_cont = bus_i.req && wait_q;
  // based on state before this cycle's gnt and rvalid
  assign phase_o.resp_ph_cont = (outst_q != '0);
  assign phase_o.addr_cnt     = addr_cnt_q;

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      wait_q     <= 1'b0;
      outst_q    <= '0;
      addr_cnt_q <= '0;
    end else begin
      wait_q <= bus_i.req && !bus_i.gnt;

      // grant and response in one cycle cancel out
      if (addr_acc && !bus_i.rvalid) begin
        outst_q <= outst_q + 1'b1;
      end else if (!addr_acc && bus_i.rvalid) begin
        outst_q <= outst_q - 1'b1;
      end

      // saturate at all ones
      if (addr_acc && (addr_cnt_q != '1)) begin
        addr_cnt_q <= addr_cnt_q + 1'b1;
      end
    end
  end

endmodule

// ==== req_attribute_fifo.sv ====
// -------------------------------------------------------------------------
// no overflow check, outstanding requests must stay at or below DEPTH
// a response may not arrive in the same cycle as its own grant
// -------------------------------------------------------------------------
module req_attribute_fifo #(
  parameter int DEPTH = 2
) (
  input  logic                 in_support_if,
  input  logic                 rst_n_i,
  input  sl_bus_pkg::obi_bus_t bus_i,
  input  logic                 attr_i,
  output logic                 resp_attr_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // one attribute bit per outstanding request
  logic [DEPTH-1:0] attr_mem;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic             push;
  logic             pop;

  // -------------------------------------------------------------------------
  // circular pointer step, wraps at DEPTH
  // -------------------------------------------------------------------------
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // push on accepted address, pop on response
  assign push = bus_i.req && bus_i.gnt;
  assign pop  = bus_i.rvalid;

  // head bit belongs to the response now arriving
  assign resp_attr_o = pop ? attr_mem[rd_ptr_q] : 1'b0;

  // pointers
  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
    end
  end

  // storage, only read through a valid head pointer
  always_ff @(posedge in_support_if) begin
    if (push) begin
      attr_mem[wr_ptr_q] <= attr_i;
    end
  end

endmodule

// ==== debug_req_tracker.sv ====
// -------------------------------------------------------------------------
// debug entry, debug request hold and start-up detection
// only untrapped dret retirements count as leaving debug mode
// -------------------------------------------------------------------------
module debug_req_tracker (
  input  logic                 in_support_if,
  input  logic                 rst_n_i,
  input  sl_core_pkg::retire_t retire_i,
  input  logic                 debug_req_i,
  input  logic                 fetch_enable_i,
  output logic                 first_debug_ins_o,
  output logic                 recorded_dbg_req_o,
  output logic                 first_fetch_o
);

  // previous retirement left the core in debug mode
  logic       in_dbg_q;
  // retirements still to pass before the request record drops
  logic [1:0] req_cnt_q;
  logic       rec_req_q;
  // fetch_enable has been seen high
  logic       fetch_seen_q;

  // -------------------------------------------------------------------------
  // debug entry
  // -------------------------------------------------------------------------
  assign first_debug_ins_o = retire_i.valid && retire_i.dbg_mode && !in_dbg_q;

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      in_dbg_q <= 1'b0;
    end else if (retire_i.valid) begin
      // an untrapped dret ends the debug session
      in_dbg_q <= retire_i.dbg_mode && !(retire_i.is_dret && !retire_i.trap);
    end
  end

  // -------------------------------------------------------------------------
  // debug request record
  // -------------------------------------------------------------------------
  assign recorded_dbg_req_o = rec_req_q;

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      rec_req_q <= 1'b0;
      req_cnt_q <= 2'd0;
    end else if (retire_i.valid) begin
      // request on a retirement, hold for one more
      if (debug_req_i) begin
        rec_req_q <= 1'b1;
        req_cnt_q <= 2'd1;
      end else if (req_cnt_q != 2'd0) begin
        req_cnt_q <= req_cnt_q - 2'd1;
      end else begin
        rec_req_q <= 1'b0;
      end
    end else if (debug_req_i) begin
      // between retirements, hold for two more
      rec_req_q <= 1'b1;
      req_cnt_q <= 2'd2;
    end
  end

  // core start-up
  assign first_fetch_o = fetch_enable_i && !fetch_seen_q;

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      fetch_seen_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fetch_seen_q <= 1'b1;
    end
  end

endmodule

// ==== exception_trigger_unit.sv ====
// -------------------------------------------------------------------------
// writes with tsel beyond MAX_TRIGGERS are dropped
// triggers at or above NUM_TRIGGERS are stored but never hit
// -------------------------------------------------------------------------
module exception_trigger_unit #(
  parameter int NUM_TRIGGERS = 4
) (
  input  logic                  in_support_if,
  input  logic                  rst_n_i,
  input  sl_core_pkg::retire_t  retire_i,
  input  sl_core_pkg::trig_wr_t trig_wr_i,
  output logic                  etrig_hit_o
);

  localparam int MAX_T = sl_core_pkg::MAX_TRIGGERS;
  localparam int TY_MSB = sl_core_pkg::TRIG_TYPE_MSB;
  localparam int TY_LSB = sl_core_pkg::TRIG_TYPE_LSB;

  logic [MAX_T-1:0][31:0]  tdata1_q;
  logic [MAX_T-1:0][31:0]  tdata2_q;
  // per trigger match, implemented triggers only
  logic [NUM_TRIGGERS-1:0] hit;
  logic                    wr_en;

  // -------------------------------------------------------------------------
  // trigger storage
  // -------------------------------------------------------------------------
  assign wr_en = trig_wr_i.wr && (int'(trig_wr_i.tsel) < MAX_T);

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      tdata1_q <= {MAX_T{sl_core_pkg::TDATA1_RESET}};
      tdata2_q <= '0;
    end else if (wr_en) begin
      // pair is written together, visible from the next cycle
      tdata1_q[trig_wr_i.tsel] <= trig_wr_i.tdata1;
      tdata2_q[trig_wr_i.tsel] <= trig_wr_i.tdata2;
    end
  end

  // -------------------------------------------------------------------------
  // hit detection
  // -------------------------------------------------------------------------
  for (genvar t = 0; t < NUM_TRIGGERS; t++) begin : g_trig
    logic type_ok;
    logic cause_ok;
    logic mode_ok;

    // type must be etrigger
    assign type_ok = (int'(tdata1_q[t][TY_MSB:TY_LSB]) == sl_core_pkg::TRIG_TYPE_ETRIGGER);
    // tdata2 holds one enable bit per exception cause
    assign cause_ok = tdata2_q[t][retire_i.exc_cause];
    // privilege of the retirement selects the mode enable
    assign mode_ok =
      (retire_i.is_mmode && tdata1_q[t][sl_core_pkg::TRIG_ET_M_BIT]) ||
      (retire_i.is_umode && tdata1_q[t][sl_core_pkg::TRIG_ET_U_BIT]);

    assign hit[t] = type_ok && cause_ok && mode_ok;
  end

  // only retirements with an exception can hit
  assign etrig_hit_o = retire_i.valid && retire_i.exception && (|hit);

endmodule

// ==== trap_event_monitor.sv ====
// -------------------------------------------------------------------------
// request-after-trap flag and saturating interrupt counters
// the exception window stays open until the next retirement
// -------------------------------------------------------------------------
module trap_event_monitor #(
  parameter int CNT_W = 8
) (
  input  logic                 in_support_if,
  input  logic                 rst_n_i,
  input  sl_core_pkg::retire_t retire_i,
  input  sl_core_pkg::ctrl_t   ctrl_i,
  input  sl_bus_pkg::obi_bus_t data_bus_i,
  input  logic                 irq_ack_i,
  output logic                 req_after_exception_o,
  output logic [CNT_W-1:0]     cnt_irq_ack_o,
  output logic [CNT_W-1:0]     cnt_rvfi_irqs_o
);

  logic trap_set;
  // window from trap pc_set to the next retirement
  logic exc_win_q;
  // data bus grant of the previous cycle
  logic gnt_q;
  logic req_after_q;
  logic count_irq;
  logic [CNT_W-1:0] cnt_ack_q;
  logic [CNT_W-1:0] cnt_irqs_q;

  // -------------------------------------------------------------------------
  // request after exception
  // -------------------------------------------------------------------------
  assign trap_set = ctrl_i.pc_set &&
                    ((ctrl_i.pc_mux == sl_core_pkg::PC_TRAP_EXC) ||
                     (ctrl_i.pc_mux == sl_core_pkg::PC_TRAP_DBE));

  assign req_after_exception_o = req_after_q;

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      exc_win_q   <= 1'b0;
      gnt_q       <= 1'b0;
      req_after_q <= 1'b0;
    end else begin
      gnt_q <= data_bus_i.gnt;
      if (trap_set) begin
        // trap cycle itself can already carry a request
        exc_win_q <= 1'b1;
        if (data_bus_i.req && gnt_q) begin
          req_after_q <= 1'b1;
        end
      end else if (retire_i.valid) begin
        exc_win_q   <= 1'b0;
        req_after_q <= 1'b0;
      end else if (exc_win_q && data_bus_i.req && gnt_q) begin
        req_after_q <= 1'b1;
      end
    end
  end

  // -------------------------------------------------------------------------
  // interrupt counters
  // -------------------------------------------------------------------------
  // causes 1024 to 1027 are not real interrupts
  assign count_irq = retire_i.valid && retire_i.intr &&
                     !(retire_i.intr_cause inside {[11'd1024:11'd1027]});

  assign cnt_irq_ack_o   = cnt_ack_q;
  assign cnt_rvfi_irqs_o = cnt_irqs_q;

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      cnt_ack_q  <= '0;
      cnt_irqs_q <= '0;
    end else begin
      // both stop at all ones
      if (irq_ack_i && (cnt_ack_q != '1)) begin
        cnt_ack_q <= cnt_ack_q + 1'b1;
      end
      if (count_irq && (cnt_irqs_q != '1)) begin
        cnt_irqs_q <= cnt_irqs_q + 1'b1;
      end
    end
  end

endmodule

// ==== support_logic.sv ====
// -------------------------------------------------------------------------
// support logic top; inputs are sampled every cycle, no back-pressure
// CNT_W must equal sl_bus_pkg::CNT_W, NUM_TRIGGERS at most MAX_TRIGGERS
// -------------------------------------------------------------------------
module support_logic #(
  parameter int CNT_W        = 8,
  parameter int FIFO_DEPTH   = 2,
  parameter int NUM_TRIGGERS = 4
) (
  input  logic                   in_support_if,
  input  logic                   rst_n_i,
  input  sl_core_pkg::retire_t   retire_i,
  input  sl_core_pkg::ctrl_t     ctrl_i,
  input  sl_core_pkg::trig_wr_t  trig_wr_i,
  input  sl_bus_pkg::obi_bus_t   instr_bus_i,
  input  sl_bus_pkg::obi_bus_t   data_bus_i,
  input  logic                   data_req_is_store_i,
  input  logic                   instr_req_integrity_i,
  input  logic                   debug_req_i,
  input  logic                   fetch_enable_i,
  input  logic                   irq_ack_i,
  output sl_bus_pkg::obi_phase_t instr_phase_o,
  output sl_bus_pkg::obi_phase_t data_phase_o,
  output logic                   data_resp_was_store_o,
  output logic                   instr_resp_had_integrity_o,
  output logic                   first_debug_ins_o,
  output logic                   recorded_dbg_req_o,
  output logic                   first_fetch_o,
  output logic                   etrig_hit_o,
  output logic                   req_after_exception_o,
  output logic [CNT_W-1:0]       cnt_irq_ack_o,
  output logic [CNT_W-1:0]       cnt_rvfi_irqs_o
);

  // -------------------------------------------------------------------------
  // bus phase monitors
  // -------------------------------------------------------------------------
  obi_phase_monitor #(.CNT_W(CNT_W)) u_instr_phase (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .bus_i         (instr_bus_i),
    .phase_o       (instr_phase_o)
  );

  obi_phase_monitor #(.CNT_W(CNT_W)) u_data_phase (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .bus_i         (data_bus_i),
    .phase_o       (data_phase_o)
  );

  // -------------------------------------------------------------------------
  // request attributes carried to their responses
  // -------------------------------------------------------------------------
  // store flag on the data bus
  req_attribute_fifo #(.DEPTH(FIFO_DEPTH)) u_data_store (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .bus_i         (data_bus_i),
    .attr_i        (data_req_is_store_i),
    .resp_attr_o   (data_resp_was_store_o)
  );

  // integrity flag on the instruction bus
  req_attribute_fifo #(.DEPTH(FIFO_DEPTH)) u_instr_integrity (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .bus_i         (instr_bus_i),
    .attr_i        (instr_req_integrity_i),
    .resp_attr_o   (instr_resp_had_integrity_o)
  );

  // -------------------------------------------------------------------------
  // retirement side trackers
  // -------------------------------------------------------------------------
  debug_req_tracker u_debug (
    .in_support_if      (in_support_if),
    .rst_n_i            (rst_n_i),
    .retire_i           (retire_i),
    .debug_req_i        (debug_req_i),
    .fetch_enable_i     (fetch_enable_i),
    .first_debug_ins_o  (first_debug_ins_o),
    .recorded_dbg_req_o (recorded_dbg_req_o),
    .first_fetch_o      (first_fetch_o)
  );

  exception_trigger_unit #(.NUM_TRIGGERS(NUM_TRIGGERS)) u_etrig (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .retire_i      (retire_i),
    .trig_wr_i     (trig_wr_i),
    .etrig_hit_o   (etrig_hit_o)
  );

  // also watches the data bus for requests after a trap
  trap_event_monitor #(.CNT_W(CNT_W)) u_trap (
    .in_support_if         (in_support_if),
    .rst_n_i               (rst_n_i),
    .retire_i              (retire_i),
    .ctrl_i                (ctrl_i),
    .data_bus_i            (data_bus_i),
    .irq_ack_i             (irq_ack_i),
    .req_after_exception_o (req_after_exception_o),
    .cnt_irq_ack_o         (cnt_irq_ack_o),
    .cnt_rvfi_irqs_o       (cnt_rvfi_irqs_o)
  );

endmodule

// ==== tb_sl_model.sv ====
// --------------------------------------------------------------------------
// reference model of the support logic outputs, stepped once per clock
// bus index 0 is the instruction bus, 1 the data bus; counters saturate at 255
// --------------------------------------------------------------------------
package tb_sl_model;

  localparam int CNT_MAX = 255;

  // bus side state
  bit wait_q [2];
  int addr_cnt [2];
  // attributes of outstanding requests, oldest first
  bit instr_q [$];
  bit data_q [$];
  // debug side state
  bit prev_dbg;
  bit prev_dret;
  int req_left;
  bit rec_req;
  bit fetch_seen;
  // trigger registers, five slots
  logic [31:0] tdata1 [5];
  logic [31:0] tdata2 [5];
  // trap window and interrupt counters
  bit win;
  bit gnt_prev;
  bit req_after;
  int cnt_ack;
  int cnt_irq;

  function automatic void reset();
    wait_q = '{1'b0, 1'b0};
    addr_cnt = '{0, 0};
    instr_q.delete();
    data_q.delete();
    prev_dbg = 1'b0;
    prev_dret = 1'b0;
    req_left = 0;
    rec_req = 1'b0;
    fetch_seen = 1'b0;
    for (int t = 0; t < 5; t++) begin
      tdata1[t] = 32'hF800_0000;
      tdata2[t] = 32'h0;
    end
    win = 1'b0;
    gnt_prev = 1'b0;
    req_after = 1'b0;
    cnt_ack = 0;
    cnt_irq = 0;
  endfunction

  function automatic int pending(input int b);
    return (b == 0) ? instr_q.size() : data_q.size();
  endfunction

  // attribute expected with a response this cycle
  function automatic bit resp_attr(input int b, input bit rvalid);
    if (!rvalid || pending(b) == 0) begin
      return 1'b0;
    end
    return (b == 0) ? instr_q[0] : data_q[0];
  endfunction

  function automatic bit first_debug(input sl_core_pkg::retire_t r);
    return r.valid && r.dbg_mode && (!prev_dbg || prev_dret);
  endfunction

  function automatic bit etrig_hit(input sl_core_pkg::retire_t r, input int num_trig);
    bit hit;
    bit mode_ok;
    hit = 1'b0;
    for (int t = 0; t < num_trig; t++) begin
      // m mode enable is bit 9, u mode enable is bit 6
      mode_ok = (r.is_mmode && tdata1[t][9]) || (r.is_umode && tdata1[t][6]);
      if (tdata1[t][31:28] == 4'd5 && tdata2[t][r.exc_cause] && mode_ok) begin
        hit = 1'b1;
      end
    end
    return r.valid && r.exception && hit;
  endfunction

  // --------------------------------------------------------------------------
  // state updates at the end of a cycle
  // --------------------------------------------------------------------------
  function automatic void step_bus(input int b, input sl_bus_pkg::obi_bus_t bus,
                                   input bit attr);
    wait_q[b] = bus.req && !bus.gnt;
    // response leaves before the new request enters
    if (bus.rvalid) begin
      if (b == 0) begin
        void'(instr_q.pop_front());
      end else begin
        void'(data_q.pop_front());
      end
    end
    if (bus.req && bus.gnt) begin
      if (b == 0) begin
        instr_q.push_back(attr);
      end else begin
        data_q.push_back(attr);
      end
      if (addr_cnt[b] < CNT_MAX) begin
        addr_cnt[b]++;
      end
    end
  endfunction

  function automatic void step_core(input sl_core_pkg::retire_t r, input sl_core_pkg::ctrl_t c,
                                    input sl_core_pkg::trig_wr_t tw,
                                    input sl_bus_pkg::obi_bus_t dbus,
                                    input bit dreq, input bit fen, input bit ack);
    bit trap_set;
    trap_set = c.pc_set && (c.pc_mux == sl_core_pkg::PC_TRAP_EXC ||
                            c.pc_mux == sl_core_pkg::PC_TRAP_DBE);
    if (r.valid) begin
      prev_dbg = r.dbg_mode;
      prev_dret = r.is_dret && !r.trap;
    end
    // request hold counted in retirements
    if (r.valid) begin
      if (dreq) begin
        rec_req = 1'b1;
        req_left = 1;
      end else if (req_left > 0) begin
        req_left--;
      end else begin
        rec_req = 1'b0;
      end
    end else if (dreq) begin
      rec_req = 1'b1;
      req_left = 2;
    end
    if (fen) begin
      fetch_seen = 1'b1;
    end
    if (tw.wr && tw.tsel < 3'd5) begin
      tdata1[tw.tsel] = tw.tdata1;
      tdata2[tw.tsel] = tw.tdata2;
    end
    if (trap_set) begin
      win = 1'b1;
      if (dbus.req && gnt_prev) begin
        req_after = 1'b1;
      end
    end else if (r.valid) begin
      win = 1'b0;
      req_after = 1'b0;
    end else if (win && dbus.req && gnt_prev) begin
      req_after = 1'b1;
    end
    gnt_prev = dbus.gnt;
    if (ack && cnt_ack < CNT_MAX) begin
      cnt_ack++;
    end
    if (r.valid && r.intr && !(r.intr_cause >= 11'd1024 && r.intr_cause <= 11'd1027) &&
        cnt_irq < CNT_MAX) begin
      cnt_irq++;
    end
  endfunction

endpackage

// ==== tb_support_logic.sv ====
// --------------------------------------------------------------------------
// random stimulus from a fixed seed with outputs checked at the falling edge
// bus drivers keep at most FIFO_DEPTH requests outstanding and answer in order
// --------------------------------------------------------------------------
module tb_support_logic;

  localparam int CNT_W        = 8;
  localparam int FIFO_DEPTH   = 2;
  localparam int NUM_TRIGGERS = 4;
  localparam int TEST_CYCLES  = 400;
  localparam int IRQ_CYCLES   = 700;
  // reset plus all test cycles and a small margin in clock periods
  localparam int WATCHDOG_TIME = (4 + 5 * TEST_CYCLES + IRQ_CYCLES + 50) * 40;

  logic                   in_support_if;
  logic                   rst_n_i;
  sl_core_pkg::retire_t   retire_i;
  sl_core_pkg::ctrl_t     ctrl_i;
  sl_core_pkg::trig_wr_t  trig_wr_i;
  sl_bus_pkg::obi_bus_t   instr_bus_i;
  sl_bus_pkg::obi_bus_t   data_bus_i;
  logic                   data_req_is_store_i;
  logic                   instr_req_integrity_i;
  logic                   debug_req_i;
  logic                   fetch_enable_i;
  logic                   irq_ack_i;
  sl_bus_pkg::obi_phase_t instr_phase_o;
  sl_bus_pkg::obi_phase_t data_phase_o;
  logic                   data_resp_was_store_o;
  logic                   instr_resp_had_integrity_o;
  logic                   first_debug_ins_o;
  logic                   recorded_dbg_req_o;
  logic                   first_fetch_o;
  logic                   etrig_hit_o;
  logic                   req_after_exception_o;
  logic [CNT_W-1:0]       cnt_irq_ack_o;
  logic [CNT_W-1:0]       cnt_rvfi_irqs_o;

  int err_cnt = 0;
  int pass_cnt = 0;
  int fail_cnt = 0;

  support_logic #(
    .CNT_W        (CNT_W),
    .FIFO_DEPTH   (FIFO_DEPTH),
    .NUM_TRIGGERS (NUM_TRIGGERS)
  ) DUT (.*);

  always #20 in_support_if = ~in_support_if;

  // --------------------------------------------------------------------------
  // comparison helpers
  // --------------------------------------------------------------------------
  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %0b actual %0b", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_cnt(input string name, input int exp, input logic [CNT_W-1:0] act);
    if (act !== CNT_W'(exp)) begin
      $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_outputs();
    check_bit("instr_phase_o.addr_ph_cont", instr_bus_i.req && tb_sl_model::wait_q[0],
              instr_phase_o.addr_ph_cont);
    check_bit("data_phase_o.addr_ph_cont", data_bus_i.req && tb_sl_model::wait_q[1],
              data_phase_o.addr_ph_cont);
    check_bit("instr_phase_o.resp_ph_cont", tb_sl_model::pending(0) != 0,
              instr_phase_o.resp_ph_cont);
    check_bit("data_phase_o.resp_ph_cont", tb_sl_model::pending(1) != 0,
              data_phase_o.resp_ph_cont);
    check_cnt("instr_phase_o.addr_cnt", tb_sl_model::addr_cnt[0], instr_phase_o.addr_cnt);
    check_cnt("data_phase_o.addr_cnt", tb_sl_model::addr_cnt[1], data_phase_o.addr_cnt);
    check_bit("instr_resp_had_integrity_o", tb_sl_model::resp_attr(0, instr_bus_i.rvalid),
              instr_resp_had_integrity_o);
    check_bit("data_resp_was_store_o", tb_sl_model::resp_attr(1, data_bus_i.rvalid),
              data_resp_was_store_o);
    check_bit("first_debug_ins_o", tb_sl_model::first_debug(retire_i), first_debug_ins_o);
    check_bit("recorded_dbg_req_o", tb_sl_model::rec_req, recorded_dbg_req_o);
    check_bit("first_fetch_o", fetch_enable_i && !tb_sl_model::fetch_seen, first_fetch_o);
    check_bit("etrig_hit_o", tb_sl_model::etrig_hit(retire_i, NUM_TRIGGERS), etrig_hit_o);
    check_bit("req_after_exception_o", tb_sl_model::req_after, req_after_exception_o);
    check_cnt("cnt_irq_ack_o", tb_sl_model::cnt_ack, cnt_irq_ack_o);
    check_cnt("cnt_rvfi_irqs_o", tb_sl_model::cnt_irq, cnt_rvfi_irqs_o);
  endtask

  // compare first and then advance the model with this cycle's inputs
  always @(negedge in_support_if) begin
    if (!rst_n_i) begin
      tb_sl_model::reset();
    end else begin
      check_outputs();
      tb_sl_model::step_bus(0, instr_bus_i, instr_req_integrity_i);
      tb_sl_model::step_bus(1, data_bus_i, data_req_is_store_i);
      tb_sl_model::step_core(retire_i, ctrl_i, trig_wr_i, data_bus_i, debug_req_i,
                             fetch_enable_i, irq_ack_i);
    end
  end

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  // legal OBI cycle where an ungranted request is held
  function automatic sl_bus_pkg::obi_bus_t rand_bus(input int b);
    sl_bus_pkg::obi_bus_t bus;
    int pend;
    pend = tb_sl_model::pending(b);
    bus.req = tb_sl_model::wait_q[b] || ($urandom % 2 == 0);
    bus.gnt = bus.req && (pend < FIFO_DEPTH) && ($urandom % 5 < 3);
    bus.rvalid = (pend > 0) && ($urandom % 2 == 0);
    return bus;
  endfunction

  task automatic drive_cycle(input int id, input int cyc);
    sl_core_pkg::retire_t  r;
    sl_core_pkg::ctrl_t    c;
    sl_core_pkg::trig_wr_t tw;
    logic dreq;
    logic ack;
    r = '0;
    c = '0;
    tw = '0;
    dreq = 1'b0;
    ack = 1'b0;
    case (id)
      3: begin
        r.valid = ($urandom % 2 == 0);
        r.dbg_mode = ($urandom % 2 == 0);
        r.is_dret = ($urandom % 4 == 0);
        r.trap = ($urandom % 4 == 0);
        dreq = ($urandom % 7 == 0);
        // single fetch enable rise that stays high for the rest of the run
        if (cyc == TEST_CYCLES / 2) begin
          fetch_enable_i <= 1'b1;
        end
      end
      4: begin
        tw.wr = ($urandom % 10 < 3);
        tw.tsel = 3'($urandom);
        tw.tdata1 = {($urandom % 3 != 0) ? 4'd5 : 4'($urandom), 28'($urandom)};
        tw.tdata2 = $urandom;
        r.valid = ($urandom % 10 < 7);
        r.exception = ($urandom % 2 == 0);
        r.exc_cause = 5'($urandom);
        r.is_mmode = ($urandom % 2 == 0);
        r.is_umode = !r.is_mmode;
      end
      5: begin
        c.pc_set = ($urandom % 6 == 0);
        c.pc_mux = sl_core_pkg::pc_mux_e'($urandom % 7);
        r.valid = ($urandom % 5 == 0);
      end
      6: begin
        ack = ($urandom % 5 != 0);
        r.valid = ($urandom % 10 != 0);
        r.intr = ($urandom % 4 != 0);
        // a quarter of the interrupts use the excluded causes
        r.intr_cause = ($urandom % 4 == 0) ? 11'(1024 + $urandom % 4) : 11'($urandom);
      end
      default: begin
      end
    endcase
    retire_i <= r;
    ctrl_i <= c;
    trig_wr_i <= tw;
    debug_req_i <= dreq;
    irq_ack_i <= ack;
    instr_bus_i <= rand_bus(0);
    data_bus_i <= rand_bus(1);
    instr_req_integrity_i <= (id != 1) && ($urandom % 2 == 0);
    data_req_is_store_i <= (id != 1) && ($urandom % 2 == 0);
  endtask

  task automatic run_test(input int id, input string name, input int cycles);
    int err_start;
    err_start = err_cnt;
    for (int cyc = 0; cyc < cycles; cyc++) begin
      @(posedge in_support_if);
      drive_cycle(id, cyc);
    end
    // let the last cycle be checked
    @(negedge in_support_if);
    #1;
    if (err_cnt == err_start) begin
      pass_cnt++;
      $display("test %0d %s: passed", id, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: %0d mismatches", id, name, err_cnt - err_start);
    end
  endtask

  // --------------------------------------------------------------------------
  // main sequence and watchdog
  // --------------------------------------------------------------------------
  initial begin
    void'($urandom(32'h79bb));
    in_support_if = 1'b0;
    rst_n_i = 1'b0;
    retire_i = '0;
    ctrl_i = '0;
    trig_wr_i = '0;
    instr_bus_i = '0;
    data_bus_i = '0;
    data_req_is_store_i = 1'b0;
    instr_req_integrity_i = 1'b0;
    debug_req_i = 1'b0;
    fetch_enable_i = 1'b0;
    irq_ack_i = 1'b0;
    repeat (4) @(posedge in_support_if);
    rst_n_i <= 1'b1;
    run_test(1, "bus phases", TEST_CYCLES);
    run_test(2, "request attributes", TEST_CYCLES);
    run_test(3, "debug tracking", TEST_CYCLES);
    run_test(4, "exception triggers", TEST_CYCLES);
    run_test(5, "request after trap", TEST_CYCLES);
    run_test(6, "interrupt counters", IRQ_CYCLES);
    $display("summary: %0d run, %0d passed, %0d failing, %0d mismatches",
             pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("timeout: run did not finish within %0d time units", WATCHDOG_TIME);
    $display("tests failed");
    $finish;
  end

endmodule

// ==== tb.f ====
sl_core_pkg.sv
sl_bus_pkg.sv
obi_phase_monitor.sv
req_attribute_fifo.sv
debug_req_tracker.sv
exception_trigger_unit.sv
trap_event_monitor.sv
support_logic.sv
tb_sl_model.sv
tb_support_logic.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_support_logic -o tb_sim \
  || { echo "build error"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "tests failed" sim.log && { echo "simulation: FAIL"; exit 1; }
grep -q "all tests passed" sim.log || { echo "simulation: no result"; exit 1; }
echo "simulation: PASS"
